// File: logic/gsim_num_pkg.sv
// fixed-point formats; sat_x and sat_acc take a sign-extended 64-bit value and clamp it
`default_nettype none

package gsim_num_pkg;

	localparam int N_UNK      = 16; // unknowns per system
	localparam int COEF_W     = 16; // width of one memory lane
	localparam int RECIP_FRAC = 14; // recip diagonal is Q2.14
	localparam int X_FRAC     = 16; // x and residual are Q16.16

	typedef logic signed [COEF_W-1:0] coef_t;     // integer a_ij or b_i
	typedef logic signed [15:0]       recip_t;
	typedef logic signed [31:0]       x_t;
	typedef logic signed [47:0]       acc_t;
	typedef logic signed [63:0]       wide_t;     // headroom for sums and products
	typedef logic [N_UNK*COEF_W-1:0]  mem_word_t; // lane k at bits 16k upward

	localparam x_t   X_MAX   = 32'sh7fff_ffff;
	localparam x_t   X_MIN   = 32'sh8000_0000;
	localparam acc_t ACC_MAX = 48'sh7fff_ffff_ffff;
	localparam acc_t ACC_MIN = 48'sh8000_0000_0000;

	function automatic x_t sat_x(input wide_t v);
		if (v > wide_t'(X_MAX))
			return X_MAX;
		if (v < wide_t'(X_MIN))
			return X_MIN;
		return x_t'(v);
	endfunction

	function automatic acc_t sat_acc(input wide_t v);
		if (v > wide_t'(ACC_MAX))
			return ACC_MAX;
		if (v < wide_t'(ACC_MIN))
			return ACC_MIN;
		return acc_t'(v);
	endfunction

endpackage

`default_nettype wire

// File: logic/gsim_sched_pkg.sv
// memory layout and schedule constants; FIFO_DEPTH must be a power of two
`default_nettype none

package gsim_sched_pkg;

	localparam int MAT_WORDS  = 18; // b, recip, then rows 0..15
	localparam int WORD_B     = 0;
	localparam int WORD_ROW0  = 2;
	localparam int ITER_COUNT = 16; // sweeps per matrix
	localparam int FIFO_DEPTH = 4;  // also the starting credit count

	typedef logic [9:0] mem_addr_t;
	typedef logic [8:0] x_addr_t;
	typedef logic [4:0] mat_idx_t;
	typedef logic [3:0] row_idx_t;
	typedef logic [$clog2(MAT_WORDS)-1:0]    word_idx_t;
	typedef logic [$clog2(ITER_COUNT)-1:0]   iter_idx_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD_B,
		S_LOAD_RECIP,
		S_ROW,
		S_ROW_WAIT,
		S_FINISH
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/gsim_row_fetch.sv
// memory must return data in request order; i_matrix_num of zero is not supported
`default_nettype none

module gsim_row_fetch (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_start,
	input  gsim_sched_pkg::mat_idx_t  i_matrix_num,
	input  logic                      i_pop,
	input  logic                      i_mem_rrdy,
	input  gsim_num_pkg::mem_word_t   i_mem_dout,
	input  logic                      i_mem_dout_vld,
	output logic                      o_mem_rreq,
	output gsim_sched_pkg::mem_addr_t o_mem_addr,
	output gsim_num_pkg::mem_word_t   o_word,
	output logic                      o_word_vld
);

	logic                      fetch_act; // schedule still has words to request
	gsim_sched_pkg::mat_idx_t  f_mat;
	gsim_sched_pkg::word_idx_t f_word;
	gsim_sched_pkg::iter_idx_t f_iter;
	gsim_sched_pkg::credit_t   credit;
	gsim_sched_pkg::credit_t   fill;
	gsim_sched_pkg::fifo_ptr_t wr_ptr;
	gsim_sched_pkg::fifo_ptr_t rd_ptr;
	gsim_num_pkg::mem_word_t   fifo_mem [gsim_sched_pkg::FIFO_DEPTH];
	logic                      accept;

	assign o_mem_rreq = fetch_act && (credit != '0); // no credit, no request
	assign accept     = o_mem_rreq && i_mem_rrdy;
	assign o_mem_addr = gsim_sched_pkg::mem_addr_t'(f_mat)
		* gsim_sched_pkg::mem_addr_t'(gsim_sched_pkg::MAT_WORDS)
		+ gsim_sched_pkg::mem_addr_t'(f_word);

	// ------------------------------------------------------------------
	// schedule walk: b, recip, then rows 0..15 once per sweep
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			fetch_act <= 1'b0;
			f_mat     <= '0;
			f_word    <= '0;
			f_iter    <= '0;
		end else if (i_start) begin
			fetch_act <= 1'b1;
			f_mat     <= '0;
			f_word    <= gsim_sched_pkg::word_idx_t'(gsim_sched_pkg::WORD_B);
			f_iter    <= '0;
		end else if (accept) begin
			if (f_word != gsim_sched_pkg::word_idx_t'(gsim_sched_pkg::MAT_WORDS - 1)) begin
				f_word <= f_word + 1'b1;
			end else if (f_iter != gsim_sched_pkg::iter_idx_t'(gsim_sched_pkg::ITER_COUNT - 1)) begin
				f_iter <= f_iter + 1'b1;
				f_word <= gsim_sched_pkg::word_idx_t'(gsim_sched_pkg::WORD_ROW0); // rows again
			end else begin
				f_iter <= '0;
				f_word <= gsim_sched_pkg::word_idx_t'(gsim_sched_pkg::WORD_B);
				f_mat  <= f_mat + 1'b1;
				if (f_mat == i_matrix_num - 1'b1)
					fetch_act <= 1'b0; // last word of last matrix
			end
		end
	end

	// credits and word FIFO
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			credit <= '0;
			fill   <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (i_start) begin
			credit <= gsim_sched_pkg::credit_t'(gsim_sched_pkg::FIFO_DEPTH);
			fill   <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			credit <= credit - gsim_sched_pkg::credit_t'(accept) + gsim_sched_pkg::credit_t'(i_pop);
			fill   <= fill + gsim_sched_pkg::credit_t'(i_mem_dout_vld)
				- gsim_sched_pkg::credit_t'(i_pop);
			if (i_mem_dout_vld)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1; // pointers wrap at depth
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_mem_dout_vld)
			fifo_mem[wr_ptr] <= i_mem_dout;
	end

	assign o_word     = fifo_mem[rd_ptr];
	assign o_word_vld = (fill != '0);

	// credits in hand plus words held plus words in flight stay at FIFO_DEPTH
	a_credit_range: assert property (@(posedge i_clk) disable iff (i_reset)
		credit <= gsim_sched_pkg::FIFO_DEPTH);
	a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
		i_mem_dout_vld |-> (fill != gsim_sched_pkg::credit_t'(gsim_sched_pkg::FIFO_DEPTH)));

endmodule

`default_nettype wire

// File: logic/gsim_sequencer.sv
// consumes words in fetch order; i_module_en must stay high from start until done
`default_nettype none

module gsim_sequencer (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_module_en,
	input  gsim_sched_pkg::mat_idx_t i_matrix_num,
	input  logic                     i_word_vld,
	input  logic                     i_x_vld,
	output logic                     o_start,
	output logic                     o_pop,
	output logic                     o_load_b,
	output logic                     o_load_recip,
	output logic                     o_row_go,
	output gsim_sched_pkg::row_idx_t o_row_idx,
	output gsim_sched_pkg::mat_idx_t o_mat_idx,
	output logic                     o_final_iter,
	output logic                     o_proc_done
);

	gsim_sched_pkg::seq_state_t state;
	gsim_sched_pkg::seq_state_t state_nxt;
	gsim_sched_pkg::mat_idx_t   mat_cnt;
	gsim_sched_pkg::iter_idx_t  iter_cnt;
	gsim_sched_pkg::row_idx_t   row_cnt;
	logic                       last_row;
	logic                       last_iter;
	logic                       last_mat;

	assign last_row  = (row_cnt == '1);
	assign last_iter = (iter_cnt == gsim_sched_pkg::iter_idx_t'(gsim_sched_pkg::ITER_COUNT - 1));
	assign last_mat  = (mat_cnt == i_matrix_num - 1'b1);

	// ------------------------------------------------------------------
	// next state and pops
	// ------------------------------------------------------------------
	always_comb begin
		state_nxt    = state;
		o_start      = 1'b0;
		o_pop        = 1'b0;
		o_load_b     = 1'b0;
		o_load_recip = 1'b0;
		o_row_go     = 1'b0;
		case (state)
			gsim_sched_pkg::S_IDLE: begin
				if (i_module_en) begin
					o_start   = 1'b1;
					state_nxt = gsim_sched_pkg::S_LOAD_B;
				end
			end
			gsim_sched_pkg::S_LOAD_B: begin
				if (i_word_vld) begin
					o_pop     = 1'b1;
					o_load_b  = 1'b1; // also clears x
					state_nxt = gsim_sched_pkg::S_LOAD_RECIP;
				end
			end
			gsim_sched_pkg::S_LOAD_RECIP: begin
				if (i_word_vld) begin
					o_pop        = 1'b1;
					o_load_recip = 1'b1;
					state_nxt    = gsim_sched_pkg::S_ROW;
				end
			end
			gsim_sched_pkg::S_ROW: begin
				if (i_word_vld) begin
					o_pop     = 1'b1;
					o_row_go  = 1'b1;
					state_nxt = gsim_sched_pkg::S_ROW_WAIT;
				end
			end
			gsim_sched_pkg::S_ROW_WAIT: begin
				if (i_x_vld) begin // x lands in the store on this edge
					if (!last_row || !last_iter)
						state_nxt = gsim_sched_pkg::S_ROW;
					else if (!last_mat)
						state_nxt = gsim_sched_pkg::S_LOAD_B;
					else
						state_nxt = gsim_sched_pkg::S_FINISH;
				end
			end
			gsim_sched_pkg::S_FINISH: begin
				if (!i_module_en)
					state_nxt = gsim_sched_pkg::S_IDLE;
			end
			default: state_nxt = gsim_sched_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state       <= gsim_sched_pkg::S_IDLE;
			mat_cnt     <= '0;
			iter_cnt    <= '0;
			row_cnt     <= '0;
			o_proc_done <= 1'b0;
		end else begin
			state       <= state_nxt;
			o_proc_done <= (state == gsim_sched_pkg::S_FINISH) && i_module_en;
			if (o_start) begin
				mat_cnt  <= '0;
				iter_cnt <= '0;
				row_cnt  <= '0;
			end else if (state == gsim_sched_pkg::S_ROW_WAIT && i_x_vld) begin
				row_cnt <= row_cnt + 1'b1; // wraps to row 0
				if (last_row) begin
					iter_cnt <= last_iter ? '0 : iter_cnt + 1'b1;
					if (last_iter)
						mat_cnt <= mat_cnt + 1'b1;
				end
			end
		end
	end

	assign o_row_idx    = row_cnt;
	assign o_mat_idx    = mat_cnt;
	assign o_final_iter = last_iter;

	// new x only comes back while a row is outstanding
	a_x_while_waiting: assert property (@(posedge i_clk) disable iff (i_reset)
		i_x_vld |-> (state == gsim_sched_pkg::S_ROW_WAIT));

endmodule

`default_nettype wire

// File: logic/gsim_dot_stage.sv
// one row per i_row_go; i_x_vec and i_b_vec must be stable in the i_row_go cycle
`default_nettype none

module gsim_dot_stage (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_row_go,
	input  gsim_sched_pkg::row_idx_t i_row_idx,
	input  gsim_num_pkg::mem_word_t  i_row_word,
	input  gsim_num_pkg::x_t         i_x_vec [gsim_num_pkg::N_UNK],
	input  gsim_num_pkg::coef_t      i_b_vec [gsim_num_pkg::N_UNK],
	output gsim_num_pkg::acc_t       o_acc,
	output logic                     o_acc_vld,
	output gsim_sched_pkg::row_idx_t o_acc_row
);

	gsim_num_pkg::acc_t  prod [gsim_num_pkg::N_UNK];
	gsim_num_pkg::wide_t prod_sum;
	gsim_num_pkg::wide_t b_fix;
	gsim_num_pkg::wide_t resid;

	// sixteen lanes, diagonal lane held at zero
	for (genvar j = 0; j < gsim_num_pkg::N_UNK; j++) begin : g_lane
		gsim_num_pkg::coef_t a_ij;
		assign a_ij    = i_row_word[gsim_num_pkg::COEF_W*j +: gsim_num_pkg::COEF_W];
		assign prod[j] = (i_row_idx == gsim_sched_pkg::row_idx_t'(j)) ? '0
			: gsim_num_pkg::acc_t'(a_ij) * gsim_num_pkg::acc_t'(i_x_vec[j]); // Q16.16
	end

	always_comb begin
		prod_sum = '0;
		for (int j = 0; j < gsim_num_pkg::N_UNK; j++) begin
			prod_sum = prod_sum + gsim_num_pkg::wide_t'(prod[j]);
		end
	end

	assign b_fix = gsim_num_pkg::wide_t'(i_b_vec[i_row_idx]) <<< gsim_num_pkg::X_FRAC;
	assign resid = b_fix - prod_sum;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			o_acc_vld <= 1'b0;
		else
			o_acc_vld <= i_row_go;
	end

	always_ff @(posedge i_clk) begin
		if (i_row_go) begin
			o_acc     <= gsim_num_pkg::sat_acc(resid);
			o_acc_row <= i_row_idx;
		end
	end

endmodule

`default_nettype wire

// File: logic/gsim_scale_stage.sv
// expects at most one residual in flight; result is floor-rounded by the arithmetic shift
`default_nettype none

module gsim_scale_stage (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  gsim_num_pkg::acc_t       i_acc,
	input  logic                     i_acc_vld,
	input  gsim_sched_pkg::row_idx_t i_acc_row,
	input  gsim_num_pkg::recip_t     i_recip_vec [gsim_num_pkg::N_UNK],
	output gsim_num_pkg::x_t         o_x_new,
	output logic                     o_x_vld,
	output gsim_sched_pkg::row_idx_t o_x_row
);

	gsim_num_pkg::wide_t prod;
	gsim_num_pkg::wide_t scaled;

	// Q16.16 times Q2.14 gives 30 fraction bits
	assign prod   = gsim_num_pkg::wide_t'(i_acc)
		* gsim_num_pkg::wide_t'(i_recip_vec[i_acc_row]);
	assign scaled = prod >>> gsim_num_pkg::RECIP_FRAC; // back to Q16.16

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			o_x_vld <= 1'b0;
		else
			o_x_vld <= i_acc_vld;
	end

	always_ff @(posedge i_clk) begin
		if (i_acc_vld) begin
			o_x_new <= gsim_num_pkg::sat_x(scaled);
			o_x_row <= i_acc_row;
		end
	end

	// sequencer waits for each x before starting the next row
	a_one_row_in_flight: assert property (@(posedge i_clk) disable iff (i_reset)
		i_acc_vld |=> !i_acc_vld);

endmodule

`default_nettype wire

// File: logic/gsim_x_store.sv
// b, recip and x are valid only after the first i_load_b of a run; no result back-pressure
`default_nettype none

module gsim_x_store (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_load_b,
	input  logic                     i_load_recip,
	input  gsim_num_pkg::mem_word_t  i_word,
	input  gsim_num_pkg::x_t         i_x_new,
	input  logic                     i_x_vld,
	input  gsim_sched_pkg::row_idx_t i_x_row,
	input  logic                     i_final_iter,
	input  gsim_sched_pkg::mat_idx_t i_mat_idx,
	output gsim_num_pkg::coef_t      o_b_vec [gsim_num_pkg::N_UNK],
	output gsim_num_pkg::recip_t     o_recip_vec [gsim_num_pkg::N_UNK],
	output gsim_num_pkg::x_t         o_x_vec [gsim_num_pkg::N_UNK],
	output logic                     o_x_wen,
	output gsim_sched_pkg::x_addr_t  o_x_addr,
	output gsim_num_pkg::x_t         o_x_data
);

	// ------------------------------------------------------------------
	// vectors
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_load_b) begin
			for (int k = 0; k < gsim_num_pkg::N_UNK; k++) begin
				o_b_vec[k] <= i_word[gsim_num_pkg::COEF_W*k +: gsim_num_pkg::COEF_W];
				o_x_vec[k] <= '0; // each system starts from x = 0
			end
		end
		if (i_load_recip) begin
			for (int k = 0; k < gsim_num_pkg::N_UNK; k++) begin
				o_recip_vec[k] <= i_word[gsim_num_pkg::COEF_W*k +: gsim_num_pkg::COEF_W];
			end
		end
		if (i_x_vld)
			o_x_vec[i_x_row] <= i_x_new; // in place, next row sees it
	end

	// result port, final sweep only
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset)
			o_x_wen <= 1'b0;
		else
			o_x_wen <= i_x_vld && i_final_iter;
	end

	always_ff @(posedge i_clk) begin
		if (i_x_vld && i_final_iter) begin
			o_x_addr <= gsim_sched_pkg::x_addr_t'({i_mat_idx, i_x_row}); // mat*16 + row
			o_x_data <= i_x_new;
		end
	end

endmodule

`default_nettype wire

// File: logic/gsim_top.sv
// run starts on i_module_en in idle; memory must answer every accepted read, in order
`default_nettype none

module gsim_top (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_module_en,
	input  gsim_sched_pkg::mat_idx_t  i_matrix_num,
	output logic                      o_proc_done,
	// matrix memory
	output logic                      o_mem_rreq,
	output gsim_sched_pkg::mem_addr_t o_mem_addr,
	input  logic                      i_mem_rrdy,
	input  gsim_num_pkg::mem_word_t   i_mem_dout,
	input  logic                      i_mem_dout_vld,
	// results
	output logic                      o_x_wen,
	output gsim_sched_pkg::x_addr_t   o_x_addr,
	output gsim_num_pkg::x_t          o_x_data
);

	logic                     start;
	logic                     pop;
	gsim_num_pkg::mem_word_t  word;
	logic                     word_vld;
	logic                     load_b;
	logic                     load_recip;
	logic                     row_go;
	gsim_sched_pkg::row_idx_t row_idx;
	gsim_sched_pkg::mat_idx_t mat_idx;
	logic                     final_iter;
	gsim_num_pkg::acc_t       acc;
	logic                     acc_vld;
	gsim_sched_pkg::row_idx_t acc_row;
	gsim_num_pkg::x_t         x_new;
	logic                     x_vld;
	gsim_sched_pkg::row_idx_t x_row;
	gsim_num_pkg::coef_t      b_vec [gsim_num_pkg::N_UNK];
	gsim_num_pkg::recip_t     recip_vec [gsim_num_pkg::N_UNK];
	gsim_num_pkg::x_t         x_vec [gsim_num_pkg::N_UNK];

	gsim_row_fetch u_fetch (
		.i_clk(i_clk), .i_reset(i_reset), .i_start(start),
		.i_matrix_num(i_matrix_num), .i_pop(pop),
		.i_mem_rrdy(i_mem_rrdy), .i_mem_dout(i_mem_dout), .i_mem_dout_vld(i_mem_dout_vld),
		.o_mem_rreq(o_mem_rreq), .o_mem_addr(o_mem_addr),
		.o_word(word), .o_word_vld(word_vld)
	);

	gsim_sequencer u_seq (
		.i_clk(i_clk), .i_reset(i_reset), .i_module_en(i_module_en),
		.i_matrix_num(i_matrix_num), .i_word_vld(word_vld), .i_x_vld(x_vld),
		.o_start(start), .o_pop(pop), .o_load_b(load_b), .o_load_recip(load_recip),
		.o_row_go(row_go), .o_row_idx(row_idx), .o_mat_idx(mat_idx),
		.o_final_iter(final_iter), .o_proc_done(o_proc_done)
	);

	// row word goes straight from the FIFO head into the multipliers
	gsim_dot_stage u_dot (
		.i_clk(i_clk), .i_reset(i_reset), .i_row_go(row_go), .i_row_idx(row_idx),
		.i_row_word(word), .i_x_vec(x_vec), .i_b_vec(b_vec),
		.o_acc(acc), .o_acc_vld(acc_vld), .o_acc_row(acc_row)
	);

	gsim_scale_stage u_scale (
		.i_clk(i_clk), .i_reset(i_reset), .i_acc(acc), .i_acc_vld(acc_vld),
		.i_acc_row(acc_row), .i_recip_vec(recip_vec),
		.o_x_new(x_new), .o_x_vld(x_vld), .o_x_row(x_row)
	);

	gsim_x_store u_xs (
		.i_clk(i_clk), .i_reset(i_reset), .i_load_b(load_b), .i_load_recip(load_recip),
		.i_word(word), .i_x_new(x_new), .i_x_vld(x_vld), .i_x_row(x_row),
		.i_final_iter(final_iter), .i_mat_idx(mat_idx),
		.o_b_vec(b_vec), .o_recip_vec(recip_vec), .o_x_vec(x_vec),
		.o_x_wen(o_x_wen), .o_x_addr(o_x_addr), .o_x_data(o_x_data)
	);

endmodule

`default_nettype wire

// File: verification/gsim_tb.sv
// memory model answers reads in order after 1 to 4 cycles; results are checked against a software model
`default_nettype none

module gsim_tb;

	localparam int     RUN_LIMIT   = 200000; // cycles allowed for one batch
	localparam int     DROP_LIMIT  = 20;
	localparam int     HOLD_CYCLES = 10;
	localparam longint RES_MAX     = 64'sh0000_7fff_ffff_ffff; // 48-bit residual range
	localparam longint RES_MIN     = -RES_MAX - 1;
	localparam longint XV_MAX      = 64'sh0000_0000_7fff_ffff;
	localparam longint XV_MIN      = -XV_MAX - 1;

	logic                      i_clk = 1'b0;
	logic                      i_reset;
	logic                      i_module_en;
	gsim_sched_pkg::mat_idx_t  i_matrix_num;
	logic                      o_proc_done;
	logic                      o_mem_rreq;
	gsim_sched_pkg::mem_addr_t o_mem_addr;
	logic                      i_mem_rrdy = 1'b0;
	gsim_num_pkg::mem_word_t   i_mem_dout = '0;
	logic                      i_mem_dout_vld = 1'b0;
	logic                      o_x_wen;
	gsim_sched_pkg::x_addr_t   o_x_addr;
	gsim_num_pkg::x_t          o_x_data;

	integer                    seed = 32'hfffd;
	logic                      slow_mem = 1'b0; // rare ready, longest latency
	logic                      clr_results = 1'b0;
	int                        val_errs = 0;
	int                        other_errs = 0;
	int                        cyc = 0;
	int                        last_due = 0;
	gsim_num_pkg::mem_word_t   mem [1024];
	gsim_num_pkg::mem_word_t   saved_mem [2*gsim_sched_pkg::MAT_WORDS];
	gsim_num_pkg::x_t          exp_x [512];
	gsim_sched_pkg::x_addr_t   addr_q [$];
	gsim_num_pkg::x_t          data_q [$];
	int                        rd_addr_q [$];
	int                        rd_due_q [$];

	gsim_top i_dut (
		.i_clk(i_clk), .i_reset(i_reset), .i_module_en(i_module_en),
		.i_matrix_num(i_matrix_num), .o_proc_done(o_proc_done),
		.o_mem_rreq(o_mem_rreq), .o_mem_addr(o_mem_addr), .i_mem_rrdy(i_mem_rrdy),
		.i_mem_dout(i_mem_dout), .i_mem_dout_vld(i_mem_dout_vld),
		.o_x_wen(o_x_wen), .o_x_addr(o_x_addr), .o_x_data(o_x_data)
	);

	initial begin
		forever #5 i_clk = ~i_clk;
	end

	// ----------------------------------------------------------------------
	// memory model and result monitor
	// ----------------------------------------------------------------------
	always @(posedge i_clk) begin
		int due;
		cyc = cyc + 1;
		if (i_reset) begin
			rd_addr_q.delete();
			rd_due_q.delete();
			i_mem_rrdy     <= 1'b0;
			i_mem_dout_vld <= 1'b0;
		end else begin
			if (o_mem_rreq && i_mem_rrdy) begin
				due = cyc + (slow_mem ? 4 : 1 + ($random(seed) & 3));
				if (due <= last_due)
					due = last_due + 1; // in order, one word per cycle
				last_due = due;
				rd_addr_q.push_back(int'(o_mem_addr));
				rd_due_q.push_back(due);
			end
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
				i_mem_dout     <= mem[rd_addr_q.pop_front()];
				i_mem_dout_vld <= 1'b1;
				void'(rd_due_q.pop_front());
			end else begin
				i_mem_dout_vld <= 1'b0;
			end
			if (slow_mem)
				i_mem_rrdy <= (($random(seed) & 7) == 0); // about one cycle in eight
			else
				i_mem_rrdy <= (($random(seed) & 3) != 0);
		end
	end

	always @(posedge i_clk) begin
		if (clr_results) begin
			addr_q.delete();
			data_q.delete();
		end else if (!i_reset && o_x_wen) begin
			addr_q.push_back(o_x_addr);
			data_q.push_back(o_x_data);
		end
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic longint clamp_range(input longint v, input longint lo, input longint hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic longint lane(input gsim_num_pkg::mem_word_t w, input int k);
		gsim_num_pkg::coef_t c;
		c = w[16*k +: 16];
		return longint'(c);
	endfunction

	task automatic compute_expected(input int n);
		longint x [16];
		longint res;
		int     base;
		for (int m = 0; m < n; m++) begin
			base = m * gsim_sched_pkg::MAT_WORDS;
			for (int i = 0; i < 16; i++)
				x[i] = 0;
			for (int it = 0; it < gsim_sched_pkg::ITER_COUNT; it++) begin
				for (int i = 0; i < 16; i++) begin
					res = lane(mem[base], i) * 65536; // b in Q16.16
					for (int j = 0; j < 16; j++)
						if (j != i)
							res -= lane(mem[base + 2 + i], j) * x[j];
					res  = clamp_range(res, RES_MIN, RES_MAX);
					x[i] = clamp_range((res * lane(mem[base + 1], i)) >>> 14, XV_MIN, XV_MAX);
				end
			end
			for (int i = 0; i < 16; i++)
				exp_x[m*16 + i] = gsim_num_pkg::x_t'(x[i]);
		end
	endtask

	// ----------------------------------------------------------------------
	// compare tasks and run control
	// ----------------------------------------------------------------------
	task automatic check_x(input gsim_num_pkg::x_t got, input gsim_num_pkg::x_t exp,
		input string what);
		if (got !== exp) begin
			val_errs++;
			$display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input gsim_sched_pkg::x_addr_t got,
		input gsim_sched_pkg::x_addr_t exp, input string what);
		if (got !== exp) begin
			val_errs++;
			$display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			val_errs++;
			$display("ERR %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
	endtask

	task automatic abort_timeout(input string what);
		other_errs++;
		$display("timeout at %0t: %s", $time, what);
		report_counts();
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic wait_done_high(input int n);
		int waited;
		waited = 0;
		do begin
			@(negedge i_clk);
			waited++;
			if (waited > RUN_LIMIT)
				abort_timeout("o_proc_done never rose");
		end while (!o_proc_done);
		check_flag(logic'(addr_q.size() == 16*n), 1'b1, "all writes seen when done rises");
	endtask

	task automatic wait_done_low();
		int waited;
		waited = 0;
		while (o_proc_done) begin
			@(negedge i_clk);
			waited++;
			if (waited > DROP_LIMIT)
				abort_timeout("o_proc_done stayed high after enable fell");
		end
	endtask

	task automatic start_run(input int n);
		@(posedge i_clk);
		clr_results  <= 1'b1;
		i_matrix_num <= gsim_sched_pkg::mat_idx_t'(n);
		@(posedge i_clk);
		clr_results <= 1'b0;
		i_module_en <= 1'b1;
	endtask

	task automatic stop_run();
		@(posedge i_clk);
		i_module_en <= 1'b0;
		wait_done_low();
	endtask

	task automatic check_results(input int n, input string label);
		check_flag(logic'(addr_q.size() == 16*n), 1'b1, {label, ": write count"});
		for (int k = 0; k < addr_q.size() && k < 16*n; k++) begin
			check_addr(addr_q[k], gsim_sched_pkg::x_addr_t'(k),
				$sformatf("%s: address of write %0d", label, k));
			check_x(data_q[k], exp_x[k], $sformatf("%s: x of write %0d", label, k));
		end
	endtask

	task automatic run_batch(input int n, input string label);
		start_run(n);
		wait_done_high(n);
		stop_run();
		check_results(n, label);
	endtask

	task automatic fill_dominant(input int n);
		int base;
		@(negedge i_clk);
		for (int m = 0; m < n; m++) begin
			base = m * gsim_sched_pkg::MAT_WORDS;
			for (int i = 0; i < 16; i++) begin
				mem[base][16*i +: 16]     = 16'($random(seed) % 1000);
				mem[base + 1][16*i +: 16] = 16'(16384 / (128 + ($random(seed) & 127))); // d > 105
				for (int j = 0; j < 16; j++)
					mem[base + 2 + i][16*j +: 16] = (j == i) ? 16'h4000 : 16'($random(seed) % 8);
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_diagonal();
		@(negedge i_clk);
		for (int k = 0; k < gsim_sched_pkg::MAT_WORDS; k++)
			mem[k] = '0;
		for (int i = 0; i < 16; i++) begin
			mem[0][16*i +: 16]     = 16'(i * 100 - 700);
			mem[1][16*i +: 16]     = 16'd16384; // 1.0 in Q2.14
			mem[2 + i][16*i +: 16] = 16'd1;
			exp_x[i] = gsim_num_pkg::x_t'((i * 100 - 700) * 65536);
		end
		run_batch(1, "diagonal");
	endtask

	task automatic test_dominant();
		fill_dominant(2);
		for (int k = 0; k < 2*gsim_sched_pkg::MAT_WORDS; k++)
			saved_mem[k] = mem[k];
		compute_expected(2);
		run_batch(2, "dominant");
	endtask

	task automatic test_saturation();
		@(negedge i_clk);
		for (int k = 0; k < gsim_sched_pkg::MAT_WORDS; k++)
			mem[k] = '0;
		for (int i = 0; i < 16; i++) begin
			mem[0][16*i +: 16] = (i % 2 == 0) ? 16'h7fff : 16'h8000;
			mem[1][16*i +: 16] = 16'(32767 - i); // just under 2.0
		end
		compute_expected(1);
		run_batch(1, "saturation");
		for (int i = 0; i < data_q.size() && i < 16; i++)
			check_x(data_q[i], (i % 2 == 0) ? gsim_num_pkg::X_MAX : gsim_num_pkg::X_MIN,
				$sformatf("saturation: clamp of row %0d", i));
	endtask

	task automatic test_backpressure();
		@(negedge i_clk);
		for (int k = 0; k < 2*gsim_sched_pkg::MAT_WORDS; k++)
			mem[k] = saved_mem[k];
		slow_mem = 1'b1;
		compute_expected(2);
		run_batch(2, "back-pressure");
		@(negedge i_clk);
		slow_mem = 1'b0;
	endtask

	task automatic test_done_handshake();
		fill_dominant(3);
		compute_expected(3);
		start_run(3);
		wait_done_high(3);
		repeat (HOLD_CYCLES) begin
			@(negedge i_clk);
			check_flag(o_proc_done, 1'b1, "done held while enable high");
		end
		stop_run();
		check_results(3, "handshake");
		@(negedge i_clk);
		check_flag(o_proc_done, 1'b0, "done low after enable fell");
		compute_expected(1);
		run_batch(1, "restart"); // second run from idle
	endtask

	initial begin
		i_reset      = 1'b1;
		i_module_en  = 1'b0;
		i_matrix_num = '0;
		for (int a = 0; a < 1024; a++)
			mem[a] = {16{gsim_sched_pkg::mem_addr_t'(a), 6'h2a}};
		repeat (5) @(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		check_flag(o_mem_rreq, 1'b0, "o_mem_rreq after reset");
		check_flag(o_x_wen, 1'b0, "o_x_wen after reset");
		check_flag(o_proc_done, 1'b0, "o_proc_done after reset");
		test_diagonal();
		test_dominant();
		test_saturation();
		test_backpressure();
		test_done_handshake();
		report_counts();
		if (val_errs == 0 && other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/gsim_num_pkg.sv
logic/gsim_sched_pkg.sv
logic/gsim_row_fetch.sv
logic/gsim_sequencer.sv
logic/gsim_dot_stage.sv
logic/gsim_scale_stage.sv
logic/gsim_x_store.sv
logic/gsim_top.sv
verification/gsim_tb.sv

// File: Makefile
# Verilator build and run for the Gauss-Seidel solver testbench

VERILATOR ?= verilator
TOP       ?= gsim_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
